/* src/data_predictor.sv */
// data predictor
// PC-indexed stride table with 2-bit confidence, candidate register
`timescale 1ns/1ps

module data_predictor #(
    parameter int ADDR_WIDTH = 32,
    parameter int HASH_WIDTH = 4
) (
    input  logic                                         clk,
    input  logic                                         rstn,
    input  logic                                         load_valid,
    input  logic [ADDR_WIDTH-1:0]                        load_addr,
    input  logic [ADDR_WIDTH-1:0]                        load_pc,
    input  logic                                         cand_ready,
    input  logic                                         fb_valid,
    input  logic                                         fb_hit,
    input  prefetch_pkg::pf_meta_u                       fb_meta,
    output logic                                         cand_valid,
    output logic [ADDR_WIDTH-prefetch_pkg::LINE_OFFSET-1:0] cand_line,
    output prefetch_pkg::pf_meta_u                       cand_meta
);

    localparam int LINE_W = ADDR_WIDTH - prefetch_pkg::LINE_OFFSET;
    localparam int DEPTH  = 1 << HASH_WIDTH;

    logic [DEPTH-1:0]      tbl_valid;
    logic [ADDR_WIDTH-1:0] tbl_pc     [DEPTH];
    logic [LINE_W-1:0]     tbl_last   [DEPTH];
    logic [LINE_W-1:0]     tbl_stride [DEPTH];
    logic [1:0]            tbl_conf   [DEPTH];

    logic [LINE_W-1:0]     load_line;
    logic [LINE_W-1:0]     pc_line;
    logic [HASH_WIDTH-1:0] idx;
    logic                  entry_hit;
    logic [LINE_W-1:0]     cur_stride;
    logic                  stride_match;
    logic [1:0]            new_conf;
    logic                  make_cand;
    logic [prefetch_pkg::IDX_MAX_BITS-1:0] meta_idx;

    assign load_line = load_addr[ADDR_WIDTH-1:prefetch_pkg::LINE_OFFSET];
    assign pc_line   = load_pc[ADDR_WIDTH-1:prefetch_pkg::LINE_OFFSET];
    assign idx       = pc_line[HASH_WIDTH-1:0] ^ pc_line[2*HASH_WIDTH-1:HASH_WIDTH];

    assign entry_hit    = tbl_valid[idx] && tbl_pc[idx] == load_pc;
    assign cur_stride   = load_line - tbl_last[idx];
    assign stride_match = entry_hit && cur_stride == tbl_stride[idx] && cur_stride != '0;

    // saturating confidence, any break in the stride starts over
    always_comb begin
        new_conf = 2'd0;
        if (stride_match) begin
            new_conf = (tbl_conf[idx] == 2'd3) ? 2'd3 : tbl_conf[idx] + 2'd1;
        end
    end

    assign make_cand = load_valid && entry_hit && new_conf >= 2'd2;
    assign meta_idx  = {{(prefetch_pkg::IDX_MAX_BITS-HASH_WIDTH){1'b0}}, idx};

    always_ff @(posedge clk) begin
        if (!rstn) begin
            tbl_valid <= '0;
        end else if (load_valid) begin
            tbl_valid[idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load_valid) begin
            tbl_last[idx] <= load_line;
            tbl_conf[idx] <= new_conf;
            if (!entry_hit) begin
                // fresh entry for this PC
                tbl_pc[idx]     <= load_pc;
                tbl_stride[idx] <= '0;
            end else if (!stride_match) begin
                tbl_stride[idx] <= cur_stride;
            end
        end
        // line was already in L2, back off
        if (fb_valid && fb_hit) begin
            tbl_conf[fb_meta.data.idx[HASH_WIDTH-1:0]] <= 2'd0;
        end
    end

    // candidate register, newest prediction wins
    always_ff @(posedge clk) begin
        if (!rstn) begin
            cand_valid <= 1'b0;
        end else if (make_cand) begin
            cand_valid <= 1'b1;
        end else if (cand_valid && cand_ready) begin
            cand_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (make_cand) begin
            cand_line           <= load_line + cur_stride;
            cand_meta.data.conf <= new_conf;
            cand_meta.data.idx  <= meta_idx;
        end
    end

    // index must fit the tag field carried through the issue unit
    a_hash_fits: assert property (
        @(posedge clk) HASH_WIDTH <= prefetch_pkg::IDX_MAX_BITS
    );

endmodule

/* src/inst_predictor.sv */
// instruction predictor
// hashed next-line table with sequential fallback, candidate register
`timescale 1ns/1ps

module inst_predictor #(
    parameter int ADDR_WIDTH = 32,
    parameter int HASH_WIDTH = 4
) (
    input  logic                                         clk,
    input  logic                                         rstn,
    input  logic                                         fetch_valid,
    input  logic [ADDR_WIDTH-1:0]                        fetch_addr,
    input  logic                                         cand_ready,
    input  logic                                         fb_valid,
    input  logic                                         fb_hit,
    input  prefetch_pkg::pf_meta_u                       fb_meta,
    output logic                                         cand_valid,
    output logic [ADDR_WIDTH-prefetch_pkg::LINE_OFFSET-1:0] cand_line,
    output prefetch_pkg::pf_meta_u                       cand_meta
);

    localparam int LINE_W = ADDR_WIDTH - prefetch_pkg::LINE_OFFSET;
    localparam int DEPTH  = 1 << HASH_WIDTH;

    logic [DEPTH-1:0]      tbl_valid;
    logic [LINE_W-1:0]     tbl_tag  [DEPTH];
    logic [LINE_W-1:0]     tbl_next [DEPTH];

    logic                  last_valid;
    logic [LINE_W-1:0]     last_line;

    logic [LINE_W-1:0]     fetch_line;
    logic                  new_fetch;
    logic [HASH_WIDTH-1:0] cur_idx;
    logic [HASH_WIDTH-1:0] last_idx;
    logic                  tbl_hit;
    logic [LINE_W-1:0]     pred_line;
    logic [prefetch_pkg::IDX_MAX_BITS-1:0] meta_idx;

    assign fetch_line = fetch_addr[ADDR_WIDTH-1:prefetch_pkg::LINE_OFFSET];

    // only act when the fetch leaves the current line
    assign new_fetch = fetch_valid && (!last_valid || fetch_line != last_line);

    assign cur_idx  = fetch_line[HASH_WIDTH-1:0] ^ fetch_line[2*HASH_WIDTH-1:HASH_WIDTH];
    assign last_idx = last_line[HASH_WIDTH-1:0] ^ last_line[2*HASH_WIDTH-1:HASH_WIDTH];

    assign tbl_hit   = tbl_valid[cur_idx] && tbl_tag[cur_idx] == fetch_line;
    assign pred_line = tbl_hit ? tbl_next[cur_idx] : fetch_line + 1'b1;
    assign meta_idx  = {{(prefetch_pkg::IDX_MAX_BITS-HASH_WIDTH){1'b0}}, cur_idx};

    always_ff @(posedge clk) begin
        if (!rstn) begin
            last_valid <= 1'b0;
            tbl_valid  <= '0;
        end else begin
            if (new_fetch) begin
                last_valid <= 1'b1;
                // previous line now points at this one
                if (last_valid) begin
                    tbl_valid[last_idx] <= 1'b1;
                end
            end
            // a useful jump already sat in L2, drop it
            if (fb_valid && fb_hit && fb_meta.inst.from_table) begin
                tbl_valid[fb_meta.inst.idx[HASH_WIDTH-1:0]] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (new_fetch) begin
            last_line <= fetch_line;
            if (last_valid) begin
                tbl_tag[last_idx]  <= last_line;
                tbl_next[last_idx] <= fetch_line;
            end
        end
    end

    // candidate register, newest prediction wins
    always_ff @(posedge clk) begin
        if (!rstn) begin
            cand_valid <= 1'b0;
        end else if (new_fetch) begin
            cand_valid <= 1'b1;
        end else if (cand_valid && cand_ready) begin
            cand_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (new_fetch) begin
            cand_line                 <= pred_line;
            cand_meta.inst.from_table <= tbl_hit;
            cand_meta.inst.spare      <= 1'b0;
            cand_meta.inst.idx        <= meta_idx;
        end
    end

    // a prediction must move away from the line that produced it
    a_cand_differs: assert property (
        @(posedge clk) disable iff (!rstn)
        new_fetch |=> cand_line != $past(fetch_line)
    );

endmodule

/* src/prefetch_issue.sv */
// prefetch issue unit
// candidate arbitration, single outstanding L2 request, feedback routing
`timescale 1ns/1ps

module prefetch_issue #(
    parameter int ADDR_WIDTH = 32
) (
    input  logic                                         clk,
    input  logic                                         rstn,
    input  logic                                         inst_cand_valid,
    input  logic [ADDR_WIDTH-prefetch_pkg::LINE_OFFSET-1:0] inst_cand_line,
    input  prefetch_pkg::pf_meta_u                       inst_cand_meta,
    input  logic                                         data_cand_valid,
    input  logic [ADDR_WIDTH-prefetch_pkg::LINE_OFFSET-1:0] data_cand_line,
    input  prefetch_pkg::pf_meta_u                       data_cand_meta,
    input  logic                                         l2_done,
    input  logic                                         l2_hit,
    output logic                                         inst_cand_ready,
    output logic                                         data_cand_ready,
    output logic                                         l2_req,
    output logic                                         l2_type,
    output logic [ADDR_WIDTH-1:0]                        l2_addr,
    output logic                                         inst_fb_valid,
    output logic                                         data_fb_valid,
    output logic                                         fb_hit,
    output prefetch_pkg::pf_meta_u                       fb_meta
);

    localparam logic ST_IDLE = 1'b0;
    localparam logic ST_REQ  = 1'b1;

    logic                   state;
    logic                   take;
    prefetch_pkg::pf_meta_u meta_q;

    // data side goes first, ready only while idle
    assign data_cand_ready = (state == ST_IDLE) && data_cand_valid;
    assign inst_cand_ready = (state == ST_IDLE) && !data_cand_valid;
    assign take            = data_cand_ready || (inst_cand_ready && inst_cand_valid);

    assign l2_req  = (state == ST_REQ);
    assign fb_meta = meta_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state         <= ST_IDLE;
            inst_fb_valid <= 1'b0;
            data_fb_valid <= 1'b0;
        end else begin
            inst_fb_valid <= 1'b0;
            data_fb_valid <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (take) begin
                        state <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (l2_done) begin
                        state         <= ST_IDLE;
                        inst_fb_valid <= (l2_type == prefetch_pkg::PF_INST);
                        data_fb_valid <= (l2_type == prefetch_pkg::PF_DATA);
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // request payload, held until completion
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && take) begin
            if (data_cand_ready) begin
                l2_type <= prefetch_pkg::PF_DATA;
                l2_addr <= {data_cand_line, {prefetch_pkg::LINE_OFFSET{1'b0}}};
                meta_q  <= data_cand_meta;
            end else begin
                l2_type <= prefetch_pkg::PF_INST;
                l2_addr <= {inst_cand_line, {prefetch_pkg::LINE_OFFSET{1'b0}}};
                meta_q  <= inst_cand_meta;
            end
        end
        if (state == ST_REQ && l2_done) begin
            fb_hit <= l2_hit;
        end
    end

    a_req_stable: assert property (
        @(posedge clk) disable iff (!rstn)
        l2_req && !l2_done |=> l2_req && $stable(l2_addr) && $stable(l2_type)
    );

    a_one_ready: assert property (
        @(posedge clk) disable iff (!rstn)
        !(inst_cand_ready && data_cand_ready)
    );

endmodule

/* src/prefetch_pkg.sv */
// shared prefetch definitions
// line geometry, request-type codes, feedback tag union

package prefetch_pkg;

    // 4-byte words, 8 words per line
    localparam int LINE_OFFSET = 5;

    // widest table index any predictor may use
    localparam int IDX_MAX_BITS = 8;

    // request type on l2_type
    localparam bit PF_INST = 1'b0;
    localparam bit PF_DATA = 1'b1;

    // tag held with an outstanding request and returned with feedback
    // the instruction side and the data side read the same 10 bits differently
    typedef union packed {
        // next-line table view
        struct packed {
            logic                    from_table;
            logic                    spare;
            logic [IDX_MAX_BITS-1:0] idx;
        } inst;
        // stride table view
        struct packed {
            logic [1:0]              conf;
            logic [IDX_MAX_BITS-1:0] idx;
        } data;
    } pf_meta_u;

endpackage

/* src/prefetch_top.sv */
// L2 prefetch engine top level
// instruction and data predictors feeding one issue unit
`timescale 1ns/1ps

module prefetch_top #(
    parameter int ADDR_WIDTH = 32,
    parameter int HASH_WIDTH = 4
) (
    input  logic                  clk,
    input  logic                  rstn,
    // L1 instruction cache fetch stream
    input  logic                  fetch_valid,
    input  logic [ADDR_WIDTH-1:0] fetch_addr,
    // L1 data cache load stream
    input  logic                  load_valid,
    input  logic [ADDR_WIDTH-1:0] load_addr,
    input  logic [ADDR_WIDTH-1:0] load_pc,
    // L2 prefetch port
    output logic                  l2_req,
    output logic                  l2_type,
    output logic [ADDR_WIDTH-1:0] l2_addr,
    input  logic                  l2_done,
    input  logic                  l2_hit
);

    localparam int LINE_W = ADDR_WIDTH - prefetch_pkg::LINE_OFFSET;

    logic                   inst_cand_valid;
    logic                   inst_cand_ready;
    logic [LINE_W-1:0]      inst_cand_line;
    prefetch_pkg::pf_meta_u inst_cand_meta;

    logic                   data_cand_valid;
    logic                   data_cand_ready;
    logic [LINE_W-1:0]      data_cand_line;
    prefetch_pkg::pf_meta_u data_cand_meta;

    logic                   inst_fb_valid;
    logic                   data_fb_valid;
    logic                   fb_hit;
    prefetch_pkg::pf_meta_u fb_meta;

    inst_predictor #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .HASH_WIDTH (HASH_WIDTH)
    ) inst_pred0 (
        .clk        (clk),
        .rstn       (rstn),
        .fetch_valid(fetch_valid),
        .fetch_addr (fetch_addr),
        .cand_ready (inst_cand_ready),
        .fb_valid   (inst_fb_valid),
        .fb_hit     (fb_hit),
        .fb_meta    (fb_meta),
        .cand_valid (inst_cand_valid),
        .cand_line  (inst_cand_line),
        .cand_meta  (inst_cand_meta)
    );

    data_predictor #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .HASH_WIDTH (HASH_WIDTH)
    ) data_pred0 (
        .clk        (clk),
        .rstn       (rstn),
        .load_valid (load_valid),
        .load_addr  (load_addr),
        .load_pc    (load_pc),
        .cand_ready (data_cand_ready),
        .fb_valid   (data_fb_valid),
        .fb_hit     (fb_hit),
        .fb_meta    (fb_meta),
        .cand_valid (data_cand_valid),
        .cand_line  (data_cand_line),
        .cand_meta  (data_cand_meta)
    );

    prefetch_issue #(
        .ADDR_WIDTH      (ADDR_WIDTH)
    ) issue0 (
        .clk             (clk),
        .rstn            (rstn),
        .inst_cand_valid (inst_cand_valid),
        .inst_cand_line  (inst_cand_line),
        .inst_cand_meta  (inst_cand_meta),
        .data_cand_valid (data_cand_valid),
        .data_cand_line  (data_cand_line),
        .data_cand_meta  (data_cand_meta),
        .l2_done         (l2_done),
        .l2_hit          (l2_hit),
        .inst_cand_ready (inst_cand_ready),
        .data_cand_ready (data_cand_ready),
        .l2_req          (l2_req),
        .l2_type         (l2_type),
        .l2_addr         (l2_addr),
        .inst_fb_valid   (inst_fb_valid),
        .data_fb_valid   (data_fb_valid),
        .fb_hit          (fb_hit),
        .fb_meta         (fb_meta)
    );

endmodule

/* verification/prefetch_tb.svh */
// prefetch testbench stimulus table and expected requests
// xorshift generator, L2 responder
`ifndef PREFETCH_TB_SVH
`define PREFETCH_TB_SVH

// row kinds
localparam int K_FETCH  = 0;
localparam int K_LOAD   = 1;
localparam int K_BOTH   = 2;
localparam int K_FETCH2 = 3;
localparam int K_IDLE   = 4;

localparam logic T_INST = prefetch_pkg::PF_INST;
localparam logic T_DATA = prefetch_pkg::PF_DATA;

localparam int NUM_ROWS = 18;

string       row_name   [NUM_ROWS];
int          row_kind   [NUM_ROWS];
logic [31:0] row_faddr  [NUM_ROWS];
logic [31:0] row_faddr2 [NUM_ROWS];
logic [31:0] row_laddr  [NUM_ROWS];
logic [31:0] row_pc     [NUM_ROWS];
logic        row_hit    [NUM_ROWS];
logic        row_exp    [NUM_ROWS];
logic        row_type   [NUM_ROWS];
logic [31:0] row_eaddr  [NUM_ROWS];
int          row_count = 0;

logic [31:0] rng_state = 32'hedac_bbb4;

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

task automatic set_row(
    input string       name,
    input int          kind,
    input logic [31:0] faddr,
    input logic [31:0] faddr2,
    input logic [31:0] laddr,
    input logic [31:0] pc,
    input logic        hit,
    input logic        exp,
    input logic        rtype,
    input logic [31:0] eaddr
);
    row_name[row_count]   = name;
    row_kind[row_count]   = kind;
    row_faddr[row_count]  = faddr;
    row_faddr2[row_count] = faddr2;
    row_laddr[row_count]  = laddr;
    row_pc[row_count]     = pc;
    row_hit[row_count]    = hit;
    row_exp[row_count]    = exp;
    row_type[row_count]   = rtype;
    row_eaddr[row_count]  = eaddr;
    row_count++;
endtask

task automatic fill_table();
    // name, kind, fetch, 2nd fetch, load, pc, l2 hit, expect, type, request addr
    set_row("seq_first",     K_FETCH,  32'h0208, 0, 0, 0, 0, 1, T_INST, 32'h0220);
    set_row("same_line",     K_FETCH,  32'h021c, 0, 0, 0, 0, 0, T_INST, 0);
    set_row("seq_fallback",  K_FETCH,  32'h0804, 0, 0, 0, 0, 1, T_INST, 32'h0820);
    set_row("jump_a",        K_FETCH,  32'h04a4, 0, 0, 0, 0, 1, T_INST, 32'h04c0);
    set_row("jump_b",        K_FETCH,  32'h0b08, 0, 0, 0, 0, 1, T_INST, 32'h0b20);
    set_row("jump_else",     K_FETCH,  32'h126c, 0, 0, 0, 0, 1, T_INST, 32'h1280);
    // second fetch lands while the jump request is outstanding
    set_row("jump_learned",  K_FETCH2, 32'h04a0, 32'h0e28, 0, 0, 1, 1, T_INST, 32'h0b00);
    set_row("jump_pending",  K_IDLE,   0, 0, 0, 0, 0, 1, T_INST, 32'h0e40);
    set_row("jump_dropped",  K_FETCH,  32'h04b0, 0, 0, 0, 0, 1, T_INST, 32'h04c0);
    set_row("stride_alloc",  K_LOAD,   0, 0, 32'h4004, 32'h1000, 0, 0, T_DATA, 0);
    set_row("stride_learn",  K_LOAD,   0, 0, 32'h4068, 32'h1000, 0, 0, T_DATA, 0);
    set_row("stride_conf1",  K_LOAD,   0, 0, 32'h40c0, 32'h1000, 0, 0, T_DATA, 0);
    set_row("stride_conf2",  K_LOAD,   0, 0, 32'h4124, 32'h1000, 1, 1, T_DATA, 32'h4180);
    set_row("stride_reset1", K_LOAD,   0, 0, 32'h418c, 32'h1000, 0, 0, T_DATA, 0);
    set_row("stride_reset2", K_LOAD,   0, 0, 32'h41e0, 32'h1000, 0, 1, T_DATA, 32'h4240);
    set_row("prio_data",     K_BOTH,   32'h06c8, 0, 32'h4250, 32'h1000, 0, 1, T_DATA, 32'h42a0);
    set_row("prio_inst",     K_IDLE,   0, 0, 0, 0, 1, 1, T_INST, 32'h06e0);
    set_row("quiet_end",     K_BOTH,   32'h06dc, 0, 32'h8000, 32'h2040, 0, 0, T_INST, 0);
endtask

// answer the open request after 1 to 4 cycles
task automatic respond_l2(input int r);
    int delay;
    int c;
    rng_state = xorshift32(rng_state);
    delay = 1 + int'(rng_state % 4);
    for (c = 0; c < delay; c++) begin
        @(negedge clk);
        check_value({row_name[r], " req held"}, 32'd1, {31'd0, l2_req});
        check_value({row_name[r], " addr held"}, row_eaddr[r], l2_addr);
        check_value({row_name[r], " type held"}, {31'd0, row_type[r]}, {31'd0, l2_type});
    end
    l2_hit  = row_hit[r];
    l2_done = 1'b1;
    @(negedge clk);
    l2_done = 1'b0;
    l2_hit  = 1'b0;
    check_value({row_name[r], " req dropped"}, 32'd0, {31'd0, l2_req});
endtask

`endif

/* verification/prefetch_tb.sv */
// L2 prefetch engine testbench
// clock, reset, table-driven rows against an L2 responder
`timescale 1ns/1ps

module prefetch_tb;

    localparam int ADDR_WIDTH   = 32;
    localparam int HASH_WIDTH   = 4;
    localparam int REQ_TIMEOUT  = 20;
    localparam int QUIET_CYCLES = 4;
    localparam logic [31:0] LOW_MASK = (32'd1 << prefetch_pkg::LINE_OFFSET) - 1;

    logic                  clk;
    logic                  rstn;
    logic                  fetch_valid;
    logic [ADDR_WIDTH-1:0] fetch_addr;
    logic                  load_valid;
    logic [ADDR_WIDTH-1:0] load_addr;
    logic [ADDR_WIDTH-1:0] load_pc;
    logic                  l2_req;
    logic                  l2_type;
    logic [ADDR_WIDTH-1:0] l2_addr;
    logic                  l2_done;
    logic                  l2_hit;

    prefetch_top #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .HASH_WIDTH (HASH_WIDTH)
    ) dut0 (
        .clk         (clk),
        .rstn        (rstn),
        .fetch_valid (fetch_valid),
        .fetch_addr  (fetch_addr),
        .load_valid  (load_valid),
        .load_addr   (load_addr),
        .load_pc     (load_pc),
        .l2_req      (l2_req),
        .l2_type     (l2_type),
        .l2_addr     (l2_addr),
        .l2_done     (l2_done),
        .l2_hit      (l2_hit)
    );

    always #20 clk = ~clk;

    task automatic stop_run();
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
            stop_run();
        end
    endtask

    `include "prefetch_tb.svh"

    task automatic drive_row(input int r);
        @(negedge clk);
        case (row_kind[r])
            K_FETCH: begin
                fetch_valid = 1'b1;
                fetch_addr  = row_faddr[r];
            end
            K_LOAD: begin
                load_valid = 1'b1;
                load_addr  = row_laddr[r];
                load_pc    = row_pc[r];
            end
            K_BOTH: begin
                fetch_valid = 1'b1;
                fetch_addr  = row_faddr[r];
                load_valid  = 1'b1;
                load_addr   = row_laddr[r];
                load_pc     = row_pc[r];
            end
            K_FETCH2: begin
                fetch_valid = 1'b1;
                fetch_addr  = row_faddr[r];
                @(negedge clk);
                fetch_addr  = row_faddr2[r];
            end
            default: begin
                // idle row lets a held candidate go out
            end
        endcase
        @(negedge clk);
        fetch_valid = 1'b0;
        load_valid  = 1'b0;
    endtask

    task automatic wait_for_req(input int r);
        int cycles;
        cycles = 0;
        while (l2_req !== 1'b1) begin
            if (cycles >= REQ_TIMEOUT) begin
                $display("ERROR: %s timed out waiting for an L2 request", row_name[r]);
                stop_run();
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic expect_quiet(input int r);
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            check_value({row_name[r], " no request"}, 32'd0, {31'd0, l2_req});
        end
    endtask

    initial begin
        int r;
        clk         = 1'b0;
        rstn        = 1'b0;
        fetch_valid = 1'b0;
        fetch_addr  = '0;
        load_valid  = 1'b0;
        load_addr   = '0;
        load_pc     = '0;
        l2_done     = 1'b0;
        l2_hit      = 1'b0;
        fill_table();

        repeat (5) begin
            @(negedge clk);
            check_value("reset req", 32'd0, {31'd0, l2_req});
        end
        rstn = 1'b1;
        @(negedge clk);
        check_value("after reset req", 32'd0, {31'd0, l2_req});

        for (r = 0; r < row_count; r++) begin
            // gap lets feedback reach the tables
            repeat (2) @(negedge clk);
            drive_row(r);
            if (row_exp[r]) begin
                wait_for_req(r);
                check_value({row_name[r], " type"}, {31'd0, row_type[r]}, {31'd0, l2_type});
                check_value({row_name[r], " line aligned"}, 32'd0, l2_addr & LOW_MASK);
                check_value({row_name[r], " addr"}, row_eaddr[r], l2_addr);
                respond_l2(r);
            end else begin
                expect_quiet(r);
            end
        end

        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+verification
src/prefetch_pkg.sv
src/inst_predictor.sv
src/data_predictor.sv
src/prefetch_issue.sv
src/prefetch_top.sv
verification/prefetch_tb.sv
